// ==== tia_object_config.svh ====
`ifndef TIA_OBJECT_CONFIG_SVH
`define TIA_OBJECT_CONFIG_SVH

// Ball, missile 0 and missile 1.
`define TIA_NUM_OBJECTS 3
`define TIA_NUM_PAIRS   3

// Position counter codes.
`define TIA_LFSR_W      6
`define TIA_LFSR_END    6'b101101
`define TIA_LFSR_ERR    6'b111111

// Host bus.
`define TIA_ADDR_W      6
`define TIA_DATA_W      8

// Shared registers above the per-object block.
`define TIA_ADDR_GRSHIFT 6'h30
`define TIA_ADDR_CXCLR   6'h31

`endif

// ==== tia_object_pkg.sv ====
package tia_object_pkg;

    // Decoded register operation, one per host write.
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_RES     = 3'd1,                   // Position reset strobe.
        OP_ENA     = 3'd2,                   // Enable, data bit 1.
        OP_SIZE    = 3'd3,                   // Size code, data bits 5:4.
        OP_VDEL    = 3'd4,                   // Vertical delay, data bit 0.
        OP_GRSHIFT = 3'd5,                   // Swaps the delayed enable.
        OP_CXCLR   = 3'd6                    // Clears all collision flags.
    } reg_op_e;

    // Object width is 2**code motion clocks.
    typedef logic [1:0] size_code_t;

    // Width in motion clocks for a size code.
    function automatic logic [3:0] size_to_width(size_code_t code);
        logic [3:0] width;
        width = 4'd1 << code;
        return width;
    endfunction

endpackage

// ==== tia_object_ctrl_if.sv ====
`timescale 1ns/1ps

interface tia_object_ctrl_if;

    logic                       res_stb;
    logic                       ena_stb;
    logic                       ena_val;
    logic                       size_stb;
    tia_object_pkg::size_code_t size_val;
    logic                       vdel_stb;
    logic                       vdel_val;
    logic                       grshift_stb;    // Same on every object.

    modport decoder (
        output res_stb,
        output ena_stb,
        output ena_val,
        output size_stb,
        output size_val,
        output vdel_stb,
        output vdel_val,
        output grshift_stb
    );

    modport counter (
        input res_stb,
        input ena_stb,
        input ena_val,
        input size_stb,
        input size_val,
        input vdel_stb,
        input vdel_val,
        input grshift_stb
    );

endinterface

// ==== tia_register_decoder.sv ====
`timescale 1ns/1ps
`include "tia_object_config.svh"

module tia_register_decoder (
    input  logic                   clkp,
    input  logic                   reset,
    input  logic                   wr_en,
    input  logic [`TIA_ADDR_W-1:0] wr_addr,
    input  logic [`TIA_DATA_W-1:0] wr_data,
    tia_object_ctrl_if.decoder     ctrl [`TIA_NUM_OBJECTS],
    output logic                   cxclr_stb
);

    localparam int IDX_W = $clog2(`TIA_NUM_OBJECTS);

    tia_object_pkg::reg_op_e    op_d;
    tia_object_pkg::reg_op_e    op_q;
    logic [IDX_W-1:0]           idx_d;
    logic [IDX_W-1:0]           idx_q;
    logic                       ena_q;
    tia_object_pkg::size_code_t size_q;
    logic                       vdel_q;

    // Four registers per object, then the two shared strobes.
    always_comb begin
        op_d  = tia_object_pkg::OP_NONE;
        idx_d = '0;
        if (wr_en) begin
            if (wr_addr == `TIA_ADDR_GRSHIFT) begin
                op_d = tia_object_pkg::OP_GRSHIFT;
            end else if (wr_addr == `TIA_ADDR_CXCLR) begin
                op_d = tia_object_pkg::OP_CXCLR;
            end else if (wr_addr[`TIA_ADDR_W-1:2] < `TIA_NUM_OBJECTS) begin
                idx_d = wr_addr[2 +: IDX_W];
                case (wr_addr[1:0])
                    2'd0:    op_d = tia_object_pkg::OP_RES;
                    2'd1:    op_d = tia_object_pkg::OP_ENA;
                    2'd2:    op_d = tia_object_pkg::OP_SIZE;
                    default: op_d = tia_object_pkg::OP_VDEL;
                endcase
            end
        end
    end

    always_ff @(posedge clkp) begin
        if (reset) begin
            op_q  <= tia_object_pkg::OP_NONE;
            idx_q <= '0;
        end else begin
            op_q  <= op_d;
            idx_q <= idx_d;
        end
    end

    // Data fields of the last write.
    always_ff @(posedge clkp) begin
        if (reset) begin
            ena_q  <= 1'b0;
            size_q <= '0;
            vdel_q <= 1'b0;
        end else if (wr_en) begin
            ena_q  <= wr_data[1];
            size_q <= wr_data[5:4];
            vdel_q <= wr_data[0];
        end
    end

    for (genvar i = 0; i < `TIA_NUM_OBJECTS; i++) begin : g_ctrl
        logic hit;

        assign hit = (idx_q == IDX_W'(i));

        assign ctrl[i].res_stb     = hit && (op_q == tia_object_pkg::OP_RES);
        assign ctrl[i].ena_stb     = hit && (op_q == tia_object_pkg::OP_ENA);
        assign ctrl[i].size_stb    = hit && (op_q == tia_object_pkg::OP_SIZE);
        assign ctrl[i].vdel_stb    = hit && (op_q == tia_object_pkg::OP_VDEL);
        assign ctrl[i].grshift_stb = (op_q == tia_object_pkg::OP_GRSHIFT);
        assign ctrl[i].ena_val     = ena_q;
        assign ctrl[i].size_val    = size_q;
        assign ctrl[i].vdel_val    = vdel_q;
    end

    assign cxclr_stb = (op_q == tia_object_pkg::OP_CXCLR);

endmodule

// ==== tia_position_counter.sv ====
`timescale 1ns/1ps
`include "tia_object_config.svh"

module tia_position_counter (
    input  logic               clkp,
    input  logic               reset,
    input  logic               motck_en,
    tia_object_ctrl_if.counter ctrl,
    output logic               obj_pix
);

    logic [1:0]                 phase;
    logic [`TIA_LFSR_W-1:0]     lfsr;
    logic [`TIA_LFSR_W-1:0]     lfsr_next;
    logic                       step;
    logic                       at_end;
    logic                       at_err;
    logic                       wrap;
    logic                       ena_new;
    logic                       ena_old;
    logic                       vdel;
    logic                       eff_en;
    tia_object_pkg::size_code_t size;
    logic [3:0]                 draw_cnt;

    // One LFSR step every fourth motion clock.
    assign step   = motck_en && (phase == 2'd3);
    assign at_end = (lfsr == `TIA_LFSR_END);
    assign at_err = (lfsr == `TIA_LFSR_ERR);
    assign wrap   = step && at_end;

    // XNOR feedback; the all-ones state would otherwise lock up.
    always_comb begin
        if (at_end || at_err) begin
            lfsr_next = '0;
        end else begin
            lfsr_next = {~(lfsr[1] ^ lfsr[0]), lfsr[`TIA_LFSR_W-1:1]};
        end
    end

    always_ff @(posedge clkp) begin
        if (reset || ctrl.res_stb) begin
            phase <= 2'd0;
        end else if (motck_en) begin
            phase <= phase + 2'd1;               // Wraps 3 to 0.
        end
    end

    always_ff @(posedge clkp) begin
        if (reset || ctrl.res_stb) begin
            lfsr <= '0;
        end else if (step) begin
            lfsr <= lfsr_next;
        end
    end

    // Width down-counter, loaded at the wrap.
    always_ff @(posedge clkp) begin
        if (reset || ctrl.res_stb) begin
            draw_cnt <= '0;                      // Drawing stops on RES.
        end else if (wrap) begin
            draw_cnt <= tia_object_pkg::size_to_width(size);
        end else if (motck_en && (draw_cnt != '0)) begin
            draw_cnt <= draw_cnt - 4'd1;
        end
    end

    // Enable, delayed enable, vertical delay and size.
    always_ff @(posedge clkp) begin
        if (reset) begin
            ena_new <= 1'b0;
            ena_old <= 1'b0;
            vdel    <= 1'b0;
            size    <= '0;
        end else begin
            if (ctrl.ena_stb) begin
                ena_new <= ctrl.ena_val;
            end
            if (ctrl.grshift_stb) begin
                ena_old <= ena_new;              // Graphics write swaps it in.
            end
            if (ctrl.vdel_stb) begin
                vdel <= ctrl.vdel_val;
            end
            if (ctrl.size_stb) begin
                size <= ctrl.size_val;
            end
        end
    end

    assign eff_en  = vdel ? ena_old : ena_new;
    assign obj_pix = eff_en && (draw_cnt != '0);

endmodule

// ==== tia_object_mixer.sv ====
`timescale 1ns/1ps
`include "tia_object_config.svh"

module tia_object_mixer (
    input  logic                        clkp,
    input  logic                        reset,
    input  logic [`TIA_NUM_OBJECTS-1:0] obj_pix_in,
    input  logic                        cxclr_stb,
    output logic [`TIA_NUM_OBJECTS-1:0] obj_pix,
    output logic                        pix_valid,
    output logic [1:0]                  pix_obj,
    output logic [`TIA_NUM_PAIRS-1:0]   collisions
);

    logic [1:0]                prio_obj;
    logic [`TIA_NUM_PAIRS-1:0] overlap;

    // Lowest index wins.
    always_comb begin
        prio_obj = 2'd0;
        for (int i = `TIA_NUM_OBJECTS - 1; i >= 0; i--) begin
            if (obj_pix_in[i]) begin
                prio_obj = 2'(i);
            end
        end
    end

    // Pairs in order 0-1, 0-2, 1-2.
    always_comb begin
        int pair;
        pair    = 0;
        overlap = '0;
        for (int a = 0; a < `TIA_NUM_OBJECTS; a++) begin
            for (int b = a + 1; b < `TIA_NUM_OBJECTS; b++) begin
                overlap[pair] = obj_pix_in[a] && obj_pix_in[b];
                pair++;
            end
        end
    end

    always_ff @(posedge clkp) begin
        if (reset) begin
            obj_pix    <= '0;
            pix_valid  <= 1'b0;
            pix_obj    <= 2'd0;
            collisions <= '0;
        end else begin
            obj_pix    <= obj_pix_in;
            pix_valid  <= |obj_pix_in;
            pix_obj    <= prio_obj;
            // A new overlap beats the clear.
            collisions <= (collisions & ~{`TIA_NUM_PAIRS{cxclr_stb}}) | overlap;
        end
    end

endmodule

// ==== tia_object_graphics.sv ====
`timescale 1ns/1ps
`include "tia_object_config.svh"

module tia_object_graphics (
    input  logic                        clkp,
    input  logic                        reset,
    input  logic                        motck_en,
    input  logic                        wr_en,
    input  logic [`TIA_ADDR_W-1:0]      wr_addr,
    input  logic [`TIA_DATA_W-1:0]      wr_data,
    output logic [`TIA_NUM_OBJECTS-1:0] obj_pix,
    output logic                        pix_valid,
    output logic [1:0]                  pix_obj,
    output logic [`TIA_NUM_PAIRS-1:0]   collisions
);

    tia_object_ctrl_if ctrl [`TIA_NUM_OBJECTS] ();

    logic [`TIA_NUM_OBJECTS-1:0] obj_pix_raw;   // Unregistered counter pixels.
    logic                        cxclr_stb;

    tia_register_decoder u_decoder (
        .clkp      (clkp),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .ctrl      (ctrl),
        .cxclr_stb (cxclr_stb)
    );

    // Ball, missile 0, missile 1.
    for (genvar i = 0; i < `TIA_NUM_OBJECTS; i++) begin : g_obj
        tia_position_counter u_counter (
            .clkp     (clkp),
            .reset    (reset),
            .motck_en (motck_en),
            .ctrl     (ctrl[i]),
            .obj_pix  (obj_pix_raw[i])
        );
    end

    tia_object_mixer u_mixer (
        .clkp       (clkp),
        .reset      (reset),
        .obj_pix_in (obj_pix_raw),
        .cxclr_stb  (cxclr_stb),
        .obj_pix    (obj_pix),
        .pix_valid  (pix_valid),
        .pix_obj    (pix_obj),
        .collisions (collisions)
    );

endmodule

// ==== tb_tia_object_graphics.sv ====
`timescale 1ns/1ps
`include "tia_object_config.svh"

module tb_tia_object_graphics;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int WRAP_MC       = 160;
    localparam int WAIT_LIMIT    = 1000;
    localparam int FREEZE_CYCLES = 300;
    // Motion clocks per test, reset through freeze.
    localparam int TEST_MC = 200 + 3 * WRAP_MC + 4 * 170 + 3 * 170 + 2 * 170 + 2 * WRAP_MC;
    localparam int TEST_CYCLES = TEST_MC * 4 / 3 + FREEZE_CYCLES + RESET_CYCLES;
    localparam longint WATCHDOG_NS = 2 * longint'(TEST_CYCLES) * CLK_PERIOD;

    logic                        clkp = 1'b0;
    logic                        reset;
    logic                        motck_en;
    logic                        wr_en;
    logic [`TIA_ADDR_W-1:0]      wr_addr;
    logic [`TIA_DATA_W-1:0]      wr_data;
    logic [`TIA_NUM_OBJECTS-1:0] obj_pix;
    logic                        pix_valid;
    logic [1:0]                  pix_obj;
    logic [`TIA_NUM_PAIRS-1:0]   collisions;

    logic [15:0] rng = 16'd20;
    logic        motion_random = 1'b1;
    int          errors = 0;
    int          checks = 0;
    int          mc_total = 0;                   // Motion clocks seen so far.
    int          mc_lag = 0;                     // Same, one edge behind the outputs.
    logic        seen_edge = 1'b0;

    // Reference model state.
    int                          m_mc [`TIA_NUM_OBJECTS];
    int                          m_draw [`TIA_NUM_OBJECTS];
    logic                        m_ena_new [`TIA_NUM_OBJECTS];
    logic                        m_ena_old [`TIA_NUM_OBJECTS];
    logic                        m_vdel [`TIA_NUM_OBJECTS];
    logic [1:0]                  m_size [`TIA_NUM_OBJECTS];
    logic                        p_valid;
    logic [`TIA_ADDR_W-1:0]      p_addr;
    logic [`TIA_DATA_W-1:0]      p_data;
    logic [`TIA_NUM_OBJECTS-1:0] m_obj_pix;
    logic                        m_valid;
    logic [1:0]                  m_obj;
    logic [`TIA_NUM_PAIRS-1:0]   m_coll;

    tia_object_graphics uut (
        .clkp       (clkp),
        .reset      (reset),
        .motck_en   (motck_en),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .obj_pix    (obj_pix),
        .pix_valid  (pix_valid),
        .pix_obj    (pix_obj),
        .collisions (collisions)
    );

    always #(CLK_PERIOD / 2) clkp = ~clkp;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    // Two bits per cycle, high unless both are zero.
    always @(negedge clkp) begin : motion_drive
        logic b0;
        logic b1;
        if (motion_random) begin
            rng = lfsr_step(rng);
            b0 = rng[0];
            rng = lfsr_step(rng);
            b1 = rng[0];
            motck_en = b0 || b1;
        end else begin
            motck_en = 1'b0;
        end
    end

    always @(posedge clkp) begin : ref_model
        logic [`TIA_NUM_OBJECTS-1:0] raw;
        logic [`TIA_NUM_PAIRS-1:0]   hits;
        logic                        clr;
        int                          off;
        int                          idx;
        seen_edge = 1'b1;
        if (reset) begin
            for (int i = 0; i < `TIA_NUM_OBJECTS; i++) begin
                m_mc[i] = 0;
                m_draw[i] = 0;
                m_ena_new[i] = 1'b0;
                m_ena_old[i] = 1'b0;
                m_vdel[i] = 1'b0;
                m_size[i] = 2'd0;
            end
            p_valid = 1'b0;
            m_obj_pix = '0;
            m_valid = 1'b0;
            m_obj = 2'd0;
            m_coll = '0;
        end else begin
            for (int i = 0; i < `TIA_NUM_OBJECTS; i++) begin
                raw[i] = (m_vdel[i] ? m_ena_old[i] : m_ena_new[i]) && (m_draw[i] != 0);
            end
            clr = p_valid && (p_addr == `TIA_ADDR_CXCLR);
            hits = {raw[1] & raw[2], raw[0] & raw[2], raw[0] & raw[1]};
            for (int p = 0; p < `TIA_NUM_PAIRS; p++) begin
                if (hits[p]) begin
                    m_coll[p] = 1'b1;            // Set wins over clear.
                end else if (clr) begin
                    m_coll[p] = 1'b0;
                end
            end
            m_obj_pix = raw;
            m_valid = |raw;
            m_obj = raw[0] ? 2'd0 : raw[1] ? 2'd1 : raw[2] ? 2'd2 : 2'd0;
            for (int i = 0; i < `TIA_NUM_OBJECTS; i++) begin
                if (motck_en && (m_mc[i] == WRAP_MC - 1)) begin
                    m_mc[i] = 0;
                    m_draw[i] = 1 << m_size[i];  // Wrap starts the pixel.
                end else if (motck_en) begin
                    m_mc[i]++;
                    if (m_draw[i] > 0) begin
                        m_draw[i]--;
                    end
                end
            end
            if (p_valid && (p_addr == `TIA_ADDR_GRSHIFT)) begin
                for (int i = 0; i < `TIA_NUM_OBJECTS; i++) begin
                    m_ena_old[i] = m_ena_new[i];
                end
            end else if (p_valid && (p_addr < 4 * `TIA_NUM_OBJECTS)) begin
                idx = p_addr / 4;
                off = p_addr % 4;
                case (off)
                    0: begin
                        m_mc[idx] = 0;
                        m_draw[idx] = 0;
                    end
                    1: m_ena_new[idx] = p_data[1];
                    2: m_size[idx] = p_data[5:4];
                    default: m_vdel[idx] = p_data[0];
                endcase
            end
            p_valid = wr_en;
            p_addr = wr_addr;
            p_data = wr_data;
            mc_lag = mc_total;
            if (motck_en) begin
                mc_total++;
            end
        end
    end

    always @(negedge clkp) begin
        if (seen_edge) begin
            check_value("obj_pix", obj_pix, m_obj_pix);
            check_value("pix_valid", pix_valid, m_valid);
            check_value("pix_obj", pix_obj, m_obj);
            check_value("collisions", collisions, m_coll);
        end
    end

    task automatic write_reg(input logic [`TIA_ADDR_W-1:0] addr,
                             input logic [`TIA_DATA_W-1:0] data);
        @(negedge clkp);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clkp);
        wr_en = 1'b0;
    endtask

    task automatic set_motion(input logic on);
        @(posedge clkp);
        motion_random = on;
    endtask

    task automatic run_motion(input int n);
        int start;
        start = mc_total;
        while (mc_total - start < n) begin
            @(negedge clkp);
        end
    endtask

    task automatic count_pixels(input logic [2:0] mask, input int n, output int seen);
        int start;
        start = mc_total;
        seen = 0;
        while (mc_total - start < n) begin
            @(negedge clkp);
            if (|(obj_pix & mask)) begin
                seen++;
            end
        end
    endtask

    // Returns the motion clock count at the rising edge.
    task automatic wait_rise(input int idx, output int mc);
        int n;
        n = 0;
        do begin
            @(negedge clkp);
            n++;
        end while (obj_pix[idx] && n < WAIT_LIMIT);
        while (!obj_pix[idx] && n < WAIT_LIMIT) begin
            @(negedge clkp);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("timeout: object %0d pixel never started", idx);
        end
        mc = mc_lag;
    endtask

    task automatic measure_pulse(input int idx, output int rise, output int len);
        int n;
        n = 0;
        wait_rise(idx, rise);
        do begin
            @(negedge clkp);
            n++;
        end while (obj_pix[idx] && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("timeout: object %0d pixel never ended", idx);
        end
        len = mc_lag - rise;
    endtask

    initial begin : main
        int base;
        int r1;
        int r2;
        int len;
        int seen;
        logic [31:0] snap;
        reset = 1'b1;
        motck_en = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (RESET_CYCLES) @(negedge clkp);
        reset = 1'b0;
        @(negedge clkp);

        // Reset state, nothing enabled.
        check_value("reset_outputs", {obj_pix, pix_valid, pix_obj, collisions}, 0);
        count_pixels(3'b111, 200, seen);
        check_value("idle_pixels", seen, 0);

        // Position and wrap on the ball.
        write_reg(6'd1, 8'h02);
        write_reg(6'd0, 8'h00);
        repeat (2) @(negedge clkp);
        base = mc_lag;
        measure_pulse(0, r1, len);
        check_value("first_rise", r1 - base, WRAP_MC);
        check_value("pulse_len", len, 1);
        measure_pulse(0, r2, len);
        check_value("wrap_period", r2 - r1, WRAP_MC);
        measure_pulse(0, r1, len);
        check_value("wrap_period", r1 - r2, WRAP_MC);

        // Sizes 1, 2, 4 and 8.
        for (int code = 0; code < 4; code++) begin
            write_reg(6'd2, 8'(code << 4));
            repeat (2) @(negedge clkp);
            measure_pulse(0, r1, len);
            check_value("pulse_len", len, 1 << code);
        end

        // Vertical delay on missile 0.
        write_reg(6'd1, 8'h00);
        write_reg(6'd7, 8'h01);
        write_reg(6'd5, 8'h02);
        write_reg(6'd4, 8'h00);
        count_pixels(3'b010, 170, seen);
        check_value("vdel_hidden", seen, 0);
        write_reg(`TIA_ADDR_GRSHIFT, 8'h00);
        measure_pulse(1, r1, len);
        check_value("vdel_pulse_len", len, 1);
        write_reg(6'd5, 8'h00);
        write_reg(6'd7, 8'h00);                  // Back to the new enable.
        count_pixels(3'b010, 170, seen);
        check_value("vdel_off_pixels", seen, 0);

        // Three aligned objects, priority and collisions.
        set_motion(1'b0);
        for (int i = 0; i < `TIA_NUM_OBJECTS; i++) begin
            write_reg(6'(4 * i + 2), 8'h30);
            write_reg(6'(4 * i + 1), 8'h02);
            write_reg(6'(4 * i), 8'h00);
        end
        write_reg(`TIA_ADDR_CXCLR, 8'h00);
        repeat (2) @(negedge clkp);
        set_motion(1'b1);
        wait_rise(0, r1);
        check_value("overlap_pix", obj_pix, 3'b111);
        check_value("overlap_prio", pix_obj, 0);
        write_reg(`TIA_ADDR_CXCLR, 8'h00);
        @(negedge clkp);
        check_value("clear_during_overlap", collisions, 3'b111);
        while (obj_pix != '0) begin
            @(negedge clkp);
        end
        write_reg(`TIA_ADDR_CXCLR, 8'h00);
        @(negedge clkp);
        check_value("clear_after_overlap", collisions, 0);

        // Motion freeze and resume.
        wait_rise(0, r1);
        run_motion(50);
        set_motion(1'b0);
        repeat (3) @(negedge clkp);
        snap = {m_obj_pix, m_valid, m_obj, m_coll};
        repeat (FREEZE_CYCLES) begin
            @(negedge clkp);
            check_value("frozen_outputs", {obj_pix, pix_valid, pix_obj, collisions}, snap);
        end
        set_motion(1'b1);
        wait_rise(0, r2);
        check_value("resume_period", r2 - r1, WRAP_MC);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tia_object_graphics.f ====
+incdir+.
tia_object_pkg.sv
tia_object_ctrl_if.sv
tia_register_decoder.sv
tia_position_counter.sv
tia_object_mixer.sv
tia_object_graphics.sv
tb_tia_object_graphics.sv
